// File: source/pio_cfg_pkg.sv
/* PIO state machine configuration
   Register map of the APB block and the configuration word it drives */
package pio_cfg_pkg;

  localparam logic [4:0] ADDR_CTRL      = 5'd0;  // Enable
  localparam logic [4:0] ADDR_CLKDIV    = 5'd4;  // Integer divider in [31:16]
  localparam logic [4:0] ADDR_EXECCTRL  = 5'd8;  // Wrap top and bottom
  localparam logic [4:0] ADDR_PINCTRL   = 5'd12; // Pin bases and counts
  localparam logic [4:0] ADDR_SHIFTCTRL = 5'd16; // Shift directions

  localparam int PIN_COUNT = 32;
  localparam int PC_W      = 5;

  typedef struct packed {
    logic        enable;
    logic [15:0] clk_div;
    logic [4:0]  wrap_top;
    logic [4:0]  wrap_bottom;
    logic [4:0]  out_base;
    logic [5:0]  out_count;
    logic [4:0]  set_base;
    logic [2:0]  set_count;
    logic [4:0]  in_base;
    logic        in_shift_right;
    logic        out_shift_right;
  } sm_cfg_t;

  // Wrap at the last word, so the program simply runs around
  localparam sm_cfg_t CFG_DEFAULT = '{wrap_top: 5'd31, default: '0};

endpackage

// File: source/pio_cfg_regs.sv
/* PIO configuration registers
   Zero-wait APB slave holding the state machine configuration */
module pio_cfg_regs (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [4:0]           paddr,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [31:0]          pwdata,
  input  pio_cfg_pkg::sm_cfg_t cfg_in,
  output logic [31:0]          prdata,
  output pio_cfg_pkg::sm_cfg_t cfg
);
  import pio_cfg_pkg::*;

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg <= cfg_in; // Power-up configuration
    end else if (psel && penable && pwrite) begin
      case (paddr)
        ADDR_CTRL: cfg.enable <= pwdata[0];
        ADDR_CLKDIV: cfg.clk_div <= pwdata[31:16];
        ADDR_EXECCTRL: begin
          cfg.wrap_top    <= pwdata[16:12];
          cfg.wrap_bottom <= pwdata[11:7];
        end
        ADDR_PINCTRL: begin
          cfg.set_count <= pwdata[28:26];
          cfg.out_count <= pwdata[25:20];
          cfg.in_base   <= pwdata[19:15];
          cfg.set_base  <= pwdata[9:5];
          cfg.out_base  <= pwdata[4:0];
        end
        ADDR_SHIFTCTRL: begin
          cfg.out_shift_right <= pwdata[19];
          cfg.in_shift_right  <= pwdata[18];
        end
        default: ; // Unmapped
      endcase
    end
  end

  always_comb begin
    prdata = '0;
    case (paddr)
      ADDR_CTRL: prdata[0] = cfg.enable;
      ADDR_CLKDIV: prdata[31:16] = cfg.clk_div;
      ADDR_EXECCTRL: prdata[16:7] = {cfg.wrap_top, cfg.wrap_bottom};
      ADDR_PINCTRL: begin
        prdata[28:15] = {cfg.set_count, cfg.out_count, cfg.in_base};
        prdata[9:0]   = {cfg.set_base, cfg.out_base};
      end
      ADDR_SHIFTCTRL: prdata[19:18] = {cfg.out_shift_right, cfg.in_shift_right};
      default: ;
    endcase
  end

endmodule

// File: source/pio_clk_div.sv
/* PIO clock divider
   Integer divider giving a one-clock execution tick every clk_div clocks */
module pio_clk_div (
  input  logic                 clk,
  input  logic                 reset,
  input  pio_cfg_pkg::sm_cfg_t cfg,
  output logic                 tick
);

  logic [15:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
      tick  <= 1'b0;
    end else if (!cfg.enable) begin
      count <= cfg.clk_div; // Parked at reload
      tick  <= 1'b0;
    end else if (count <= 16'd1) begin
      count <= cfg.clk_div; // Divider 0 and 1 tick every clock
      tick  <= 1'b1;
    end else begin
      count <= count - 16'd1;
      tick  <= 1'b0;
    end
  end

endmodule

// File: source/pio_exec.sv
/* PIO instruction execute
   Decodes the current instruction into datapath strobes and the new value */
module pio_exec (
  input  logic                   tick,
  input  logic                   delaying,
  input  pio_isa_pkg::instr_t    instr,
  input  pio_cfg_pkg::sm_cfg_t   cfg,
  input  logic [31:0]            x,
  input  logic [31:0]            y,
  input  logic [31:0]            isr,
  input  logic [31:0]            osr,
  input  logic [5:0]             isr_count,
  input  logic [5:0]             osr_count,
  input  logic [31:0]            pins_in,
  input  pio_isa_pkg::tx_fifo_t  tx,
  input  logic                   rx_full,
  output pio_isa_pkg::exec_ctl_t ctl
);
  import pio_isa_pkg::*;

  logic [2:0]  op1;
  logic [4:0]  op2;
  logic [5:0]  bit_count;
  logic [2:0]  src_code;
  logic [31:0] in_rot;
  logic [31:0] src_val;
  logic [31:0] isr_valid;
  logic [31:0] osr_valid;
  logic [31:0] out_val;

  // Keeps count bits at the low or the high end of a word
  function automatic logic [31:0] keep_bits(input logic [31:0] word, input logic [5:0] count,
                                            input logic top);
    logic [31:0] mask;
    mask = top ? ~(32'hffff_ffff >> count) : ((32'd1 << count) - 32'd1);
    return word & mask;
  endfunction

  assign op1       = instr.low.gen.op1;
  assign op2       = instr.low.gen.op2;
  assign bit_count = (op2 == 5'd0) ? 6'd32 : {1'b0, op2};
  assign src_code  = (instr.opcode == OP_MOV) ? instr.low.mov.mov_source : op1;
  assign in_rot    = (pins_in >> cfg.in_base) | (pins_in << (6'd32 - cfg.in_base));

  // Only the bits the shift registers really hold
  assign isr_valid = keep_bits(isr, isr_count, cfg.in_shift_right);
  assign osr_valid = keep_bits(osr, 6'd32 - osr_count, !cfg.out_shift_right);
  assign out_val   = cfg.out_shift_right ? keep_bits(osr_valid, bit_count, 1'b0)
                                         : osr_valid >> (6'd32 - bit_count);

  always_comb begin
    case (src_code)
      SRC_PINS: src_val = in_rot;
      SRC_X:    src_val = x;
      SRC_Y:    src_val = y;
      SRC_ISR:  src_val = isr;
      SRC_OSR:  src_val = osr;
      SRC_NULL: src_val = '0;
      default:  src_val = '0; // Reserved
    endcase
  end

  always_comb begin
    ctl = '0;
    if (tick && !delaying) begin
      case (instr.opcode)
        OP_JMP: begin
          ctl.new_val = {27'd0, op2};
          case (op1)
            3'd0: ctl.jump = 1'b1;
            3'd1: ctl.jump = (x == '0);
            3'd2: begin
              ctl.jump  = (x != '0);
              ctl.dec_x = 1'b1; // Decrements even from zero
            end
            3'd3: ctl.jump = (y == '0);
            3'd4: begin
              ctl.jump  = (y != '0);
              ctl.dec_y = 1'b1;
            end
            3'd5: ctl.jump = (x != y);
            default: ;
          endcase
        end
        OP_SET: begin
          ctl.new_val = {27'd0, op2};
          case (op1)
            DST_PINS:    ctl.set_pins = 1'b1;
            DST_X:       ctl.set_x    = 1'b1;
            DST_Y:       ctl.set_y    = 1'b1;
            DST_PINDIRS: ctl.set_dirs = 1'b1;
            default: ;
          endcase
        end
        OP_MOV: begin
          case (instr.low.mov.mov_op)
            MOVOP_NONE: ctl.new_val = src_val;
            MOVOP_INV:  ctl.new_val = ~src_val;
            MOVOP_REV:  ctl.new_val = {<<{src_val}};
            default:    ctl.new_val = src_val; // Reserved
          endcase
          case (instr.low.mov.destination)
            DST_PINS: ctl.out_pins = 1'b1;
            DST_X:    ctl.set_x    = 1'b1;
            DST_Y:    ctl.set_y    = 1'b1;
            DST_ISR:  ctl.isr_load = 1'b1;
            DST_OSR:  ctl.osr_load = 1'b1;
            default: ;
          endcase
        end
        OP_IN: begin
          ctl.shift_in    = 1'b1;
          ctl.shift_count = op2;
          ctl.new_val     = keep_bits(src_val, bit_count, 1'b0);
        end
        OP_OUT: begin
          ctl.shift_out   = 1'b1;
          ctl.shift_count = op2;
          ctl.new_val     = out_val;
          case (op1)
            DST_PINS:    ctl.out_pins = 1'b1;
            DST_X:       ctl.set_x    = 1'b1;
            DST_Y:       ctl.set_y    = 1'b1;
            DST_PINDIRS: ctl.out_dirs = 1'b1;
            DST_NULL: ; // Bits are discarded
            default: ;
          endcase
        end
        OP_PUSH_PULL: begin
          if (!op1[2]) begin
            if (!rx_full) begin
              ctl.push    = 1'b1;
              ctl.rx_word = isr_valid;
            end else begin
              ctl.stall = op1[0]; // Non-blocking drops the data
            end
          end else if (!tx.tx_empty) begin
            ctl.pull = 1'b1;
          end else if (op1[0]) begin
            ctl.stall = 1'b1;
          end else begin
            ctl.osr_load = 1'b1; // Empty FIFO, OSR takes X
            ctl.new_val  = x;
          end
        end
        default: ; // Dropped opcodes run as NOP
      endcase
    end
  end

endmodule

// File: source/pio_isa_pkg.sv
/* PIO instruction set
   Opcodes, operand codes, the instruction word and the execute control word */
package pio_isa_pkg;

  localparam logic [2:0] OP_JMP       = 3'd0;
  localparam logic [2:0] OP_IN        = 3'd2;
  localparam logic [2:0] OP_OUT       = 3'd3;
  localparam logic [2:0] OP_PUSH_PULL = 3'd4; // Bit 7 high for PULL
  localparam logic [2:0] OP_MOV       = 3'd5;
  localparam logic [2:0] OP_SET       = 3'd7;

  localparam logic [2:0] DST_PINS    = 3'd0;
  localparam logic [2:0] DST_X       = 3'd1;
  localparam logic [2:0] DST_Y       = 3'd2;
  localparam logic [2:0] DST_NULL    = 3'd3;
  localparam logic [2:0] DST_PINDIRS = 3'd4;
  localparam logic [2:0] DST_ISR     = 3'd6;
  localparam logic [2:0] DST_OSR     = 3'd7;

  localparam logic [2:0] SRC_PINS = 3'd0;
  localparam logic [2:0] SRC_X    = 3'd1;
  localparam logic [2:0] SRC_Y    = 3'd2;
  localparam logic [2:0] SRC_NULL = 3'd3;
  localparam logic [2:0] SRC_ISR  = 3'd6;
  localparam logic [2:0] SRC_OSR  = 3'd7;

  localparam logic [1:0] MOVOP_NONE = 2'd0;
  localparam logic [1:0] MOVOP_INV  = 2'd1;
  localparam logic [1:0] MOVOP_REV  = 2'd2;

  typedef union packed {
    struct packed {
      logic [2:0] op1; // Condition, destination or source
      logic [4:0] op2; // Address, data or bit count
    } gen;
    struct packed {
      logic [2:0] destination;
      logic [1:0] mov_op;
      logic [2:0] mov_source;
    } mov;
  } operand_u;

  typedef struct packed {
    logic [2:0] opcode;
    logic [4:0] delay;
    operand_u   low;
  } instr_t;

  typedef struct packed {
    logic        jump;
    logic        set_x;
    logic        set_y;
    logic        dec_x;
    logic        dec_y;
    logic        set_pins;
    logic        set_dirs;
    logic        out_pins;
    logic        out_dirs;
    logic        isr_load;
    logic        osr_load;
    logic        shift_in;
    logic        shift_out;
    logic        push;
    logic        pull;
    logic        stall;
    logic [31:0] new_val;
    logic [4:0]  shift_count; // 0 stands for 32
    logic [31:0] rx_word;
  } exec_ctl_t;

  typedef struct packed {
    logic [31:0] tx_data;
    logic        tx_empty;
  } tx_fifo_t;

endpackage

// File: source/pio_shift_unit.sv
/* PIO shift registers
   ISR and OSR with saturating shift counters */
module pio_shift_unit (
  input  logic                   clk,
  input  logic                   reset,
  input  pio_cfg_pkg::sm_cfg_t   cfg,
  input  pio_isa_pkg::exec_ctl_t ctl,
  input  pio_isa_pkg::tx_fifo_t  tx,
  output logic [31:0]            isr,
  output logic [31:0]            osr,
  output logic [5:0]             isr_count,
  output logic [5:0]             osr_count
);

  logic [5:0] bit_count;

  function automatic logic [5:0] sat_add(input logic [5:0] count, input logic [5:0] step);
    logic [6:0] sum;
    sum = count + step;
    return (sum > 7'd32) ? 6'd32 : sum[5:0];
  endfunction

  assign bit_count = (ctl.shift_count == 5'd0) ? 6'd32 : {1'b0, ctl.shift_count};

  always_ff @(posedge clk) begin
    if (reset) begin
      isr       <= '0;
      isr_count <= '0;
    end else if (ctl.push) begin
      isr       <= '0;
      isr_count <= '0;
    end else if (ctl.isr_load) begin
      isr       <= ctl.new_val;
      isr_count <= 6'd32; // A loaded ISR counts as full
    end else if (ctl.shift_in) begin
      if (cfg.in_shift_right) begin
        isr <= (isr >> bit_count) | (ctl.new_val << (6'd32 - bit_count)); // New bits at the top
      end else begin
        isr <= (isr << bit_count) | ctl.new_val;
      end
      isr_count <= sat_add(isr_count, bit_count);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      osr       <= '0;
      osr_count <= '0;
    end else if (ctl.pull) begin
      osr       <= tx.tx_data;
      osr_count <= '0;
    end else if (ctl.osr_load) begin
      osr       <= ctl.new_val;
      osr_count <= '0;
    end else if (ctl.shift_out) begin
      osr       <= cfg.out_shift_right ? osr >> bit_count : osr << bit_count;
      osr_count <= sat_add(osr_count, bit_count);
    end
  end

endmodule

// File: source/pio_sm.sv
/* PIO state machine top level
   Connects configuration, divider, execute unit and datapath */
module pio_sm (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [4:0]                         paddr,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [31:0]                        pwdata,
  output logic [31:0]                        prdata,
  input  pio_isa_pkg::instr_t                instr,
  output logic [pio_cfg_pkg::PC_W-1:0]       pc,
  input  logic [pio_cfg_pkg::PIN_COUNT-1:0]  pins_in,
  output logic [pio_cfg_pkg::PIN_COUNT-1:0]  pins_out,
  output logic [pio_cfg_pkg::PIN_COUNT-1:0]  pin_dirs,
  input  logic [31:0]                        tx_data,
  input  logic                               tx_empty,
  output logic                               pull,
  input  logic                               rx_full,
  output logic                               push,
  output logic [31:0]                        rx_data
);
  import pio_cfg_pkg::*;
  import pio_isa_pkg::*;

  sm_cfg_t     cfg;
  exec_ctl_t   ctl;
  tx_fifo_t    tx;
  logic        tick;
  logic        delaying;
  logic [31:0] x;
  logic [31:0] y;
  logic [31:0] isr;
  logic [31:0] osr;
  logic [5:0]  isr_count;
  logic [5:0]  osr_count;

  assign tx.tx_data  = tx_data;
  assign tx.tx_empty = tx_empty;
  assign push        = ctl.push;
  assign pull        = ctl.pull;
  assign rx_data     = ctl.rx_word;

  pio_cfg_regs i_regs (
    .clk(clk), .reset(reset), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .cfg_in(CFG_DEFAULT), .prdata(prdata), .cfg(cfg)
  );

  pio_clk_div i_div (.clk(clk), .reset(reset), .cfg(cfg), .tick(tick));

  pio_exec i_exec (
    .tick(tick), .delaying(delaying), .instr(instr), .cfg(cfg), .x(x), .y(y),
    .isr(isr), .osr(osr), .isr_count(isr_count), .osr_count(osr_count),
    .pins_in(pins_in), .tx(tx), .rx_full(rx_full), .ctl(ctl)
  );

  pio_shift_unit i_shift (
    .clk(clk), .reset(reset), .cfg(cfg), .ctl(ctl), .tx(tx), .isr(isr), .osr(osr),
    .isr_count(isr_count), .osr_count(osr_count)
  );

  pio_state i_state (
    .clk(clk), .reset(reset), .tick(tick), .cfg(cfg), .ctl(ctl), .delay(instr.delay),
    .pc(pc), .x(x), .y(y), .pins_out(pins_out), .pin_dirs(pin_dirs), .delaying(delaying)
  );

endmodule

// File: source/pio_state.sv
/* PIO machine state
   Program counter with wrap, scratch X and Y, delay counter, pins and directions */
module pio_state (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               tick,
  input  pio_cfg_pkg::sm_cfg_t               cfg,
  input  pio_isa_pkg::exec_ctl_t             ctl,
  input  logic [4:0]                         delay,
  output logic [pio_cfg_pkg::PC_W-1:0]       pc,
  output logic [31:0]                        x,
  output logic [31:0]                        y,
  output logic [pio_cfg_pkg::PIN_COUNT-1:0]  pins_out,
  output logic [pio_cfg_pkg::PIN_COUNT-1:0]  pin_dirs,
  output logic                               delaying
);
  import pio_cfg_pkg::*;

  logic [4:0] delay_cnt;

  // Writes count bits of val from base upwards, wrapping at the last pin
  function automatic logic [PIN_COUNT-1:0] write_field(input logic [PIN_COUNT-1:0] word,
      input logic [31:0] val, input logic [4:0] base, input logic [5:0] count);
    logic [PIN_COUNT-1:0] res;
    logic [4:0]           pos;
    res = word;
    for (int i = 0; i < PIN_COUNT; i++) begin
      pos = base + i[4:0];
      if (i < count) res[pos] = val[i];
    end
    return res;
  endfunction

  assign delaying = (delay_cnt != 5'd0);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc        <= '0;
      delay_cnt <= '0;
    end else if (tick) begin
      if (delaying) begin
        delay_cnt <= delay_cnt - 5'd1; // Idle tick
      end else if (!ctl.stall) begin
        delay_cnt <= delay;
        if (ctl.jump) pc <= ctl.new_val[PC_W-1:0];
        else if (pc == cfg.wrap_top) pc <= cfg.wrap_bottom;
        else pc <= pc + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      x <= '0;
      y <= '0;
    end else begin
      if (ctl.set_x) x <= ctl.new_val;
      else if (ctl.dec_x) x <= x - 32'd1;
      if (ctl.set_y) y <= ctl.new_val;
      else if (ctl.dec_y) y <= y - 32'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pins_out <= '0;
      pin_dirs <= '0;
    end else begin
      if (ctl.set_pins) pins_out <= write_field(pins_out, ctl.new_val, cfg.set_base,
                                                {3'd0, cfg.set_count});
      else if (ctl.out_pins) pins_out <= write_field(pins_out, ctl.new_val, cfg.out_base,
                                                     cfg.out_count);
      if (ctl.set_dirs) pin_dirs <= write_field(pin_dirs, ctl.new_val, cfg.set_base,
                                                {3'd0, cfg.set_count});
      else if (ctl.out_dirs) pin_dirs <= write_field(pin_dirs, ctl.new_val, cfg.out_base,
                                                     cfg.out_count);
    end
  end

endmodule

// File: sources.f
source/pio_cfg_pkg.sv
source/pio_isa_pkg.sv
source/pio_cfg_regs.sv
source/pio_clk_div.sv
source/pio_exec.sv
source/pio_shift_unit.sv
source/pio_state.sv
source/pio_sm.sv
tb/pio_sm_props.sv
tb/pio_sm_tb.sv

// File: tb/pio_sm_props.sv
/* PIO state machine handshake checks
   FIFO strobes against their flags, and pc against the execution tick */
module pio_sm_props (
  input logic                         clk,
  input logic                         reset,
  input logic                         tick,
  input logic                         push,
  input logic                         pull,
  input logic                         rx_full,
  input logic                         tx_empty,
  input logic [pio_cfg_pkg::PC_W-1:0] pc
);

  int fails = 0; // Read by the testbench at the end of the run

  push_needs_room: assert property (@(posedge clk) disable iff (reset) push |-> !rx_full)
    else begin
      $error("push strobe while the RX FIFO is full");
      fails++;
    end

  pull_needs_data: assert property (@(posedge clk) disable iff (reset) pull |-> !tx_empty)
    else begin
      $error("pull strobe while the TX FIFO is empty");
      fails++;
    end

  // pc only moves at the edge that ends a tick
  pc_waits_for_tick: assert property (@(posedge clk) disable iff (reset) !tick |=> $stable(pc))
    else begin
      $error("pc changed without an execution tick");
      fails++;
    end

  one_fifo_strobe: assert property (@(posedge clk) disable iff (reset) !(push && pull))
    else begin
      $error("push and pull in the same clock");
      fails++;
    end

endmodule

bind pio_sm pio_sm_props i_props (
  .clk(clk), .reset(reset), .tick(tick), .push(push), .pull(pull),
  .rx_full(rx_full), .tx_empty(tx_empty), .pc(pc)
);

// File: tb/pio_sm_tb.sv
/* PIO state machine testbench
   Runs a table of short programs, acting as instruction memory and both FIFOs */
module pio_sm_tb;
  import pio_cfg_pkg::*;
  import pio_isa_pkg::*;

  localparam int NUM_ROWS = 10;

  typedef struct packed {
    logic [7:0][15:0] prog;
    sm_cfg_t          cfg;
    logic [4:0]       halt;       // Address of the JMP to itself
    logic [3:0]       tx_avail;   // Words ready in the TX FIFO
    logic [7:0]       rx_hold;    // Clocks of rx_full after enable
    logic [4:0]       hold_pc;
    logic [4:0]       watch_pc;
    logic [7:0]       watch_clks; // 0 skips the dwell check
    logic [31:0]      pins_in;
    logic [31:0]      exp_pins;
    logic [31:0]      exp_dirs;
    logic [3:0]       exp_pushes;
    logic [31:0]      exp_word;
  } test_row_t;

  logic        clk;
  logic        reset;
  logic [4:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic [15:0] instr;
  logic [4:0]  pc;
  logic [31:0] pins_in;
  logic [31:0] pins_out;
  logic [31:0] pin_dirs;
  logic [31:0] tx_data;
  logic        tx_empty;
  logic        pull;
  logic        rx_full;
  logic        push;
  logic [31:0] rx_data;

  test_row_t   rows [NUM_ROWS];
  string       names [NUM_ROWS];
  test_row_t   cur;
  logic [31:0] tx_mem [4];
  logic [31:0] rx_q [$];
  logic        pull_seen;
  int          tx_rd;
  int          dwell;
  int          errors;
  int          row_errors;
  int          passed;
  integer      seed;

  pio_sm i_dut (
    .clk(clk), .reset(reset), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .instr(instr), .pc(pc),
    .pins_in(pins_in), .pins_out(pins_out), .pin_dirs(pin_dirs), .tx_data(tx_data),
    .tx_empty(tx_empty), .pull(pull), .rx_full(rx_full), .push(push), .rx_data(rx_data)
  );

  assign instr    = cur.prog[pc[2:0]]; // Program memory read by pc
  assign tx_empty = (tx_rd >= cur.tx_avail);
  assign tx_data  = tx_mem[tx_rd[1:0]];

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    repeat (NUM_ROWS * 400) @(posedge clk);
    $display("Timeout: a program never reached its halt address");
    $display("Done: errors found");
    $finish;
  end

  // FIFO side and pc dwell, sampled mid-cycle
  always @(negedge clk) begin
    pull_seen = pull;
    if (push) rx_q.push_back(rx_data);
    if (pc == cur.watch_pc) dwell++;
  end

  always @(posedge clk) begin
    #2;
    if (pull_seen) tx_rd++; // Next TX word after the DUT took one
  end

  function automatic logic [15:0] encode(input logic [2:0] opcode, input logic [4:0] delay,
                                         input logic [2:0] op1, input logic [4:0] op2);
    return {opcode, delay, op1, op2};
  endfunction

  function automatic logic [15:0] encode_mov(input logic [2:0] dst, input logic [1:0] mop,
                                             input logic [2:0] src);
    return {OP_MOV, 5'd0, dst, mop, src};
  endfunction

  function automatic logic [15:0] jump_self(input logic [4:0] addr);
    return {OP_JMP, 5'd0, 3'd0, addr};
  endfunction

  // Word 0 first; the two spare words hold JMP 0
  function automatic logic [7:0][15:0] program_of(input logic [15:0] w0, input logic [15:0] w1,
      input logic [15:0] w2, input logic [15:0] w3, input logic [15:0] w4,
      input logic [15:0] w5);
    return {16'h0, 16'h0, w5, w4, w3, w2, w1, w0};
  endfunction

  function automatic test_row_t new_row(input logic [7:0][15:0] prog, input logic [4:0] halt);
    test_row_t r;
    r               = '0;
    r.prog          = prog;
    r.halt          = halt;
    r.cfg.clk_div   = 16'd1;
    r.cfg.wrap_top  = 5'd31; // No wrap
    r.cfg.out_count = 6'd32;
    return r;
  endfunction

  function automatic logic [31:0] exec_word(input sm_cfg_t c);
    return {15'd0, c.wrap_top, c.wrap_bottom, 7'd0};
  endfunction

  function automatic logic [31:0] pin_word(input sm_cfg_t c);
    return {3'd0, c.set_count, c.out_count, c.in_base, 5'd0, c.set_base, c.out_base};
  endfunction

  function automatic logic [31:0] shift_word(input sm_cfg_t c);
    return {12'd0, c.out_shift_right, c.in_shift_right, 18'd0};
  endfunction

  task automatic build_table;
    test_row_t        r;
    logic [7:0][15:0] p;
    r = new_row(program_of(encode(OP_SET, 5'd0, DST_PINDIRS, 5'd31),
                           encode(OP_SET, 5'd0, DST_PINS, 5'd29),
                           encode(OP_SET, 5'd0, DST_PINS, 5'd2), jump_self(5'd3),
                           16'h0, 16'h0), 5'd3);
    r.cfg.clk_div     = 16'd3;
    r.cfg.wrap_top    = 5'd1; // Word 2 is skipped
    r.cfg.wrap_bottom = 5'd3;
    r.cfg.set_base    = 5'd4;
    r.cfg.set_count   = 3'd3;
    r.watch_pc        = 5'd1;
    r.watch_clks      = 8'd3;
    r.exp_pins        = 32'h0000_0050;
    r.exp_dirs        = 32'h0000_0070;
    rows[0] = r;
    names[0] = "SET with wrap and divider";
    r = new_row(program_of(encode(OP_SET, 5'd0, DST_PINS, 5'd31),
                           encode(OP_SET, 5'd0, DST_X, 5'd5),
                           encode(OP_SET, 5'd0, DST_Y, 5'd9), encode(OP_JMP, 5'd0, 3'd2, 5'd2),
                           encode_mov(DST_PINS, MOVOP_INV, SRC_X), jump_self(5'd5)), 5'd5);
    r.cfg.set_count = 3'd5;
    r.watch_pc      = 5'd2;
    r.watch_clks    = 8'd6; // Loop body runs X + 1 times
    rows[1] = r;
    names[1] = "X loop and MOV invert";
    r = new_row(program_of(encode(OP_SET, 5'd0, DST_Y, 5'd11),
                           encode_mov(DST_PINS, MOVOP_REV, SRC_Y), jump_self(5'd2),
                           16'h0, 16'h0, 16'h0), 5'd2);
    r.cfg.clk_div = 16'd2;
    r.exp_pins    = 32'hD000_0000;
    rows[2] = r;
    names[2] = "MOV bit reverse";
    p = program_of(encode(OP_PUSH_PULL, 5'd0, 3'b101, 5'd0), encode(OP_OUT, 5'd0, DST_PINS, 5'd8),
                   jump_self(5'd2), 16'h0, 16'h0, 16'h0);
    r = new_row(p, 5'd2);
    r.tx_avail            = 4'd1;
    r.cfg.out_count       = 6'd8;
    r.cfg.out_shift_right = 1'b1;
    r.exp_pins            = {24'd0, tx_mem[0][7:0]};
    rows[3] = r;
    names[3] = "OUT shifting right";
    r.cfg.out_shift_right = 1'b0;
    r.exp_pins            = {24'd0, tx_mem[0][31:24]};
    rows[4] = r;
    names[4] = "OUT shifting left";
    p = program_of(encode(OP_SET, 5'd0, DST_X, 5'h16), encode(OP_IN, 5'd0, SRC_PINS, 5'd8),
                   encode(OP_IN, 5'd0, SRC_X, 5'd8), encode(OP_PUSH_PULL, 5'd0, 3'b001, 5'd0),
                   jump_self(5'd4), 16'h0);
    r = new_row(p, 5'd4);
    r.pins_in     = 32'h12A5_C33C; // Byte C3 sits at in_base
    r.cfg.in_base = 5'd8;
    r.exp_pushes  = 4'd1;
    r.exp_word    = 32'h0000_C316;
    rows[5] = r;
    names[5] = "IN and PUSH shifting left";
    r.cfg.in_shift_right = 1'b1;
    r.exp_word           = 32'h16C3_0000;
    rows[6] = r;
    names[6] = "IN and PUSH shifting right";
    r = new_row(program_of(encode(OP_SET, 5'd0, DST_X, 5'd7),
                           encode_mov(DST_ISR, MOVOP_NONE, SRC_X),
                           encode(OP_PUSH_PULL, 5'd0, 3'b001, 5'd0), jump_self(5'd3),
                           16'h0, 16'h0), 5'd3);
    r.rx_hold    = 8'd20;
    r.hold_pc    = 5'd2;
    r.exp_pushes = 4'd1;
    r.exp_word   = 32'd7;
    rows[7] = r;
    names[7] = "blocking PUSH on a full RX FIFO";
    r = new_row(program_of(encode(OP_SET, 5'd0, DST_X, 5'd19),
                           encode(OP_PUSH_PULL, 5'd0, 3'b100, 5'd0),
                           encode_mov(DST_PINS, MOVOP_NONE, SRC_OSR), jump_self(5'd3),
                           16'h0, 16'h0), 5'd3);
    r.exp_pins = 32'd19; // X through the OSR
    rows[8] = r;
    names[8] = "non-blocking PULL on an empty TX FIFO";
    r = new_row(program_of(encode(OP_SET, 5'd3, DST_PINS, 5'd1),
                           encode(OP_SET, 5'd0, DST_PINS, 5'd2), jump_self(5'd2),
                           16'h0, 16'h0, 16'h0), 5'd2);
    r.cfg.set_count = 3'd2;
    r.watch_pc      = 5'd1;
    r.watch_clks    = 8'd4; // Own tick plus 3 idle ticks
    r.exp_pins      = 32'd2;
    rows[9] = r;
    names[9] = "instruction delay";
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      row_errors++;
    end
  endtask

  task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
    @(posedge clk);
    #2;
    psel   = 1'b1;
    pwrite = 1'b1;
    paddr  = addr;
    pwdata = data;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
    @(posedge clk);
    #2;
    psel  = 1'b1;
    paddr = addr;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(negedge clk);
    data = prdata; // Access phase
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic run_row(input int idx);
    logic [31:0] got;
    @(posedge clk);
    #2;
    reset = 1'b1;
    @(posedge clk);
    #2;
    cur     = rows[idx];
    pins_in = cur.pins_in;
    rx_full = (cur.rx_hold != 0);
    repeat (4) @(posedge clk);
    #2;
    reset      = 1'b0;
    tx_rd      = 0;
    dwell      = 0;
    row_errors = 0;
    rx_q.delete();
    apb_write(ADDR_CLKDIV, {cur.cfg.clk_div, 16'd0});
    apb_write(ADDR_EXECCTRL, exec_word(cur.cfg));
    apb_write(ADDR_PINCTRL, pin_word(cur.cfg));
    apb_write(ADDR_SHIFTCTRL, shift_word(cur.cfg));
    apb_read(ADDR_EXECCTRL, got);
    check_value("EXECCTRL readback", got, exec_word(cur.cfg));
    apb_read(ADDR_PINCTRL, got);
    check_value("PINCTRL readback", got, pin_word(cur.cfg));
    apb_write(ADDR_CTRL, 32'd1);
    if (cur.rx_hold != 0) begin
      repeat (cur.rx_hold) @(posedge clk);
      #2;
      check_value("pc held by the blocking PUSH", pc, cur.hold_pc);
      rx_full = 1'b0;
    end
    while (pc !== cur.halt) @(negedge clk);
    repeat (2) @(negedge clk);
    check_value("pins_out", pins_out, cur.exp_pins);
    check_value("pin_dirs", pin_dirs, cur.exp_dirs);
    check_value("push count", rx_q.size(), cur.exp_pushes);
    check_value("pull count", tx_rd, cur.tx_avail); // Every offered TX word is taken
    if (rx_q.size() > 0 && cur.exp_pushes > 0) check_value("pushed word", rx_q[0], cur.exp_word);
    if (cur.watch_clks != 0) check_value("clocks at watched pc", dwell, cur.watch_clks);
    if (row_errors == 0) begin
      passed++;
      $display("Test %0d, %s: passed", idx, names[idx]);
    end else begin
      errors += row_errors;
      $display("Test %0d, %s: failed with %0d errors", idx, names[idx], row_errors);
    end
  endtask

  initial begin
    reset   = 1'b1;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    pins_in = '0;
    rx_full = 1'b0;
    cur     = '0;
    tx_rd   = 0;
    dwell   = 0;
    errors  = 0;
    passed  = 0;
    seed    = 32'he2b9;
    for (int i = 0; i < 4; i++) tx_mem[i] = $random(seed);
    build_table();
    for (int i = 0; i < NUM_ROWS; i++) run_row(i);
    errors += i_dut.i_props.fails; // Bound assertion failures
    $display("Summary: %0d of %0d tests passed, %0d errors", passed, NUM_ROWS, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
